// File: config_sequencer.sv
`timescale 1ns/1ps

module config_sequencer (
   input  logic                              clk,
   input  logic                              rst_n,
   input  logic                              load,
   input  logic [msx_upload_pkg::RAM_AW-1:0] conf_size,
   input  logic                              hdr_valid,
   input  logic [7:0]                        rd_data,
   input  logic                              reader_busy,
   input  logic                              fill_busy,
   input  logic                              fill_done,
   input  logic [msx_upload_pkg::DDR_AW-1:0] fill_next_src,
   input  msx_upload_pkg::block_t            slot_rd_a_data,
   output logic                              reset_rq,
   output logic                              hdr_req,
   output logic [msx_upload_pkg::DDR_AW-1:0] hdr_addr,
   output logic                              fill_start,
   output logic [msx_upload_pkg::RAM_AW-1:0] fill_base,
   output logic [msx_upload_pkg::DDR_AW-1:0] fill_src,
   output logic [msx_upload_pkg::RAM_AW-1:0] fill_bytes,
   output msx_upload_pkg::fill_mode_t        fill_mode,
   output logic                              slot_wr_en,
   output logic [5:0]                        slot_wr_idx,
   output msx_upload_pkg::block_t            slot_wr_data,
   output logic [5:0]                        slot_rd_a_idx,
   output logic                              lookup_wr_en,
   output logic [3:0]                        lookup_wr_idx,
   output msx_upload_pkg::lookup_ram_t       lookup_wr_data,
   output msx_upload_pkg::bios_config_t      bios_config
);
   import msx_upload_pkg::*;

   typedef enum logic [2:0] {
      S_IDLE, S_CLEAN, S_READ_HDR, S_CHECK, S_FILL, S_STORE
   } state_t;

   state_t            state;
   logic [7:0]        hdr [HDR_BYTES];
   logic [3:0]        byte_idx;
   logic              rd_pend;
   logic [5:0]        clean_idx;
   logic [1:0]        page;
   logic [RAM_AW-1:0] ram_ptr;
   logic [3:0]        ref_ram;
   logic              filled;
   logic              past_end;
   logic              sig_ok;
   config_typ_t       typ;
   data_id_t          data_id;
   logic [10:0]       pages;
   logic [3:0]        slot_sub;
   logic [1:0]        page_mode;
   logic [1:0]        page_param;

   assign typ        = config_typ_t'(hdr[3][7:4]);
   assign slot_sub   = hdr[3][3:0];
   assign data_id    = data_id_t'(hdr[4]);
   assign pages      = {hdr[5][2:0], hdr[6]};
   assign page_mode  = hdr[9][2*page +: 2];
   assign page_param = hdr[10][2*page +: 2];
   assign sig_ok     = {hdr[0], hdr[1], hdr[2]} == SIGNATURE;
   assign past_end   = hdr_addr >= DDR_AW'(conf_size);

   assign reset_rq = state != S_IDLE;
   assign hdr_req  = (state == S_READ_HDR) & ~rd_pend & ~reader_busy & ~fill_busy
                   & ~((byte_idx == 4'd0) & past_end);

   // Fill request and its lookup entry come straight from the checked header
   assign fill_start = (state == S_CHECK) & sig_ok & (typ == SLOT_INTERNAL)
                     & (pages != '0) & (data_id != ROM_NONE);
   assign fill_base  = ram_ptr;
   assign fill_src   = hdr_addr;
   assign fill_bytes = RAM_AW'(pages) << PAGE_SHIFT;
   assign fill_mode  = (data_id == ROM_RAM) ? FILL_CHECKER : FILL_COPY;

   assign lookup_wr_en   = fill_start;
   assign lookup_wr_idx  = ref_ram;
   assign lookup_wr_data = '{ram_ptr, 16'(pages), data_id != ROM_RAM};

   assign slot_rd_a_idx = {slot_sub, page_param};

   always_comb begin
      slot_wr_en   = 1'b0;
      slot_wr_idx  = {slot_sub, page};
      slot_wr_data = slot_rd_a_data;                // Mode 1 mirrors another page
      if (state == S_CLEAN) begin
         slot_wr_en   = 1'b1;
         slot_wr_idx  = clean_idx;
         slot_wr_data = '{MAPPER_UNUSED, DEVICE_NONE, 4'd0, 2'd0, 1'b0};
      end else if (state == S_STORE) begin
         slot_wr_en = page_mode != 2'd0;
         case (page_mode)
            2'd2:    slot_wr_data = '{mapper_t'(hdr[8]), device_t'(hdr[7]),
                                      ref_ram, page_param, 1'b0};
            2'd3:    slot_wr_data = '{MAPPER_UNUSED, device_t'(hdr[7]),
                                      ref_ram, page_param, 1'b0};
            default: ;
         endcase
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state       <= S_IDLE;
         hdr_addr    <= '0;
         byte_idx    <= '0;
         rd_pend     <= 1'b0;
         clean_idx   <= '0;
         page        <= '0;
         ram_ptr     <= '0;
         ref_ram     <= '0;
         filled      <= 1'b0;
         bios_config <= '0;
      end else begin
         if (hdr_req) rd_pend <= 1'b1;
         else if (hdr_valid) rd_pend <= 1'b0;

         if (load) begin
            state     <= S_CLEAN;
            hdr_addr  <= '0;
            byte_idx  <= '0;
            clean_idx <= '0;
            ram_ptr   <= '0;
            ref_ram   <= '0;
            filled    <= 1'b0;
         end else begin
            case (state)
               S_CLEAN: begin
                  clean_idx <= clean_idx + 6'd1;
                  if (clean_idx == 6'(SLOT_ENTRIES - 1)) state <= S_READ_HDR;
               end
               S_READ_HDR: begin
                  if (byte_idx == 4'd0 && !rd_pend && past_end) state <= S_IDLE;
                  if (hdr_req) hdr_addr <= hdr_addr + 1'b1;
                  if (hdr_valid) begin
                     byte_idx <= byte_idx + 4'd1;
                     if (byte_idx == 4'(HDR_BYTES - 1)) state <= S_CHECK;
                  end
               end
               S_CHECK: begin
                  page  <= '0;
                  state <= S_READ_HDR;
                  if (!sig_ok) begin
                     state <= S_IDLE;                // Not a record, end of walk
                  end else begin
                     case (typ)
                        KBD_LAYOUT:    hdr_addr <= hdr_addr + DDR_AW'(KBD_SKIP);
                        CONFIG:        bios_config <= '{hdr[4][3:0], hdr[4][5:4]};
                        SLOT_INTERNAL: state <= fill_start ? S_FILL : S_STORE;
                        default: ;
                     endcase
                  end
               end
               S_FILL: begin
                  if (fill_done) begin
                     ram_ptr  <= ram_ptr + fill_bytes;
                     hdr_addr <= fill_next_src;      // Next header follows the ROM data
                     filled   <= 1'b1;
                     state    <= S_STORE;
                  end
               end
               S_STORE: begin
                  page <= page + 2'd1;
                  if (page == 2'd3) begin
                     ref_ram <= ref_ram + 4'(filled);
                     filled  <= 1'b0;
                     state   <= S_READ_HDR;
                  end
               end
               default: ;
            endcase
         end
      end
   end

   always_ff @(posedge clk) begin
      if (state == S_READ_HDR && hdr_valid) hdr[byte_idx] <= rd_data;
   end

endmodule

// File: ddr_byte_reader.sv
`timescale 1ns/1ps

module ddr_byte_reader (
   input  logic                              clk,
   input  logic                              rst_n,
   input  logic                              hdr_req,
   input  logic [msx_upload_pkg::DDR_AW-1:0] hdr_addr,
   input  logic                              fill_req,
   input  logic [msx_upload_pkg::DDR_AW-1:0] fill_addr,
   input  logic [7:0]                        ddr_dat_i,
   input  logic                              ddr_ack,
   output logic                              busy,
   output logic [7:0]                        rd_data,
   output logic                              hdr_valid,
   output logic                              fill_valid,
   output logic                              ddr_cyc,
   output logic                              ddr_stb,
   output logic [msx_upload_pkg::DDR_AW-1:0] ddr_adr
);

   logic owner_fill;
   logic start;

   assign start   = ~ddr_cyc & (hdr_req | fill_req);
   assign busy    = ddr_cyc;
   assign ddr_stb = ddr_cyc;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ddr_cyc    <= 1'b0;
         owner_fill <= 1'b0;
         hdr_valid  <= 1'b0;
         fill_valid <= 1'b0;
      end else begin
         hdr_valid  <= 1'b0;
         fill_valid <= 1'b0;
         if (ddr_cyc && ddr_ack) begin
            ddr_cyc    <= 1'b0;
            hdr_valid  <= ~owner_fill;
            fill_valid <= owner_fill;
         end else if (start) begin
            ddr_cyc    <= 1'b1;
            owner_fill <= ~hdr_req;                // Header fetch wins a tie
         end
      end
   end

   always_ff @(posedge clk) begin
      if (start) ddr_adr <= hdr_req ? hdr_addr : fill_addr;
      if (ddr_cyc && ddr_ack) rd_data <= ddr_dat_i;
   end

endmodule

// File: entry_table.sv
`timescale 1ns/1ps

module entry_table #(
   parameter type entry_t = msx_upload_pkg::block_t,
   parameter int  DEPTH   = msx_upload_pkg::SLOT_ENTRIES
) (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     wr_en,
   input  logic [$clog2(DEPTH)-1:0] wr_idx,
   input  entry_t                   wr_data,
   input  logic [$clog2(DEPTH)-1:0] rd_a_idx,
   input  logic [$clog2(DEPTH)-1:0] rd_b_idx,
   output entry_t                   rd_a_data,
   output entry_t                   rd_b_data
);

   entry_t entries [DEPTH];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < DEPTH; i++) begin
            entries[i] <= '0;
         end
      end else if (wr_en) begin
         entries[wr_idx] <= wr_data;
      end
   end

   assign rd_a_data = entries[rd_a_idx];
   assign rd_b_data = entries[rd_b_idx];

endmodule

// File: msx_upload.f
msx_upload_pkg.sv
upload_trigger.sv
ddr_byte_reader.sv
entry_table.sv
ram_filler.sv
config_sequencer.sv
msx_upload_top.sv
tb_wb_mem_models.sv
tb_msx_upload.sv

// File: msx_upload_pkg.sv
package msx_upload_pkg;

   localparam int DDR_AW         = 28;
   localparam int RAM_AW         = 27;
   localparam int HDR_BYTES      = 16;
   localparam int SLOT_ENTRIES   = 64;               // 4 slots x 4 subslots x 4 pages
   localparam int LOOKUP_ENTRIES = 16;
   localparam int PAGE_SHIFT     = 14;               // 16 KB pages
   localparam int KBD_SKIP       = 512;

   localparam logic [23:0] SIGNATURE = "MSX";

   typedef enum logic [3:0] {
      SLOT_INTERNAL = 4'd5,
      KBD_LAYOUT    = 4'd6,
      CONFIG        = 4'd7
   } config_typ_t;

   typedef enum logic [7:0] {
      MAPPER_NONE       = 8'd0,
      MAPPER_RAM        = 8'd1,
      MAPPER_ASCII8     = 8'd2,
      MAPPER_ASCII16    = 8'd3,
      MAPPER_KONAMI     = 8'd4,
      MAPPER_KONAMI_SCC = 8'd5,
      MAPPER_UNUSED     = 8'hFF
   } mapper_t;

   typedef enum logic [7:0] {
      DEVICE_NONE = 8'd0,
      DEVICE_FDC  = 8'd1,
      DEVICE_SCC  = 8'd2
   } device_t;

   typedef enum logic [7:0] {
      ROM_NONE = 8'd0,
      ROM_RAM  = 8'd1,
      ROM_ROM  = 8'd2                                // Any other id also means copy
   } data_id_t;

   typedef enum logic {
      FILL_COPY    = 1'b0,
      FILL_CHECKER = 1'b1
   } fill_mode_t;

   typedef struct packed {
      mapper_t    mapper;
      device_t    device;
      logic [3:0] ref_ram;
      logic [1:0] offset_ram;
      logic       cart_num;
   } block_t;

   typedef struct packed {
      logic [RAM_AW-1:0] addr;
      logic [15:0]       size;                       // In 16 KB pages
      logic              ro;
   } lookup_ram_t;

   typedef struct packed {
      logic [3:0] slot_expander_en;
      logic [1:0] msx_typ;
   } bios_config_t;

endpackage

// File: msx_upload_top.sv
`timescale 1ns/1ps

module msx_upload_top (
   input  logic                              clk,
   input  logic                              rst_n,
   input  logic                              ioctl_download,
   input  logic [15:0]                       ioctl_index,
   input  logic [msx_upload_pkg::RAM_AW-1:0] ioctl_addr,
   input  logic [7:0]                        ddr_dat_i,
   input  logic                              ddr_ack,
   input  logic                              ram_ack,
   input  logic [5:0]                        slot_rd_idx,
   input  logic [3:0]                        lookup_rd_idx,
   output logic                              reset_rq,
   output logic                              ddr_cyc,
   output logic                              ddr_stb,
   output logic [msx_upload_pkg::DDR_AW-1:0] ddr_adr,
   output logic                              ram_cyc,
   output logic                              ram_stb,
   output logic [msx_upload_pkg::RAM_AW-1:0] ram_adr,
   output logic [7:0]                        ram_dat_o,
   output msx_upload_pkg::bios_config_t      bios_config,
   output msx_upload_pkg::block_t            slot_rd_data,
   output msx_upload_pkg::lookup_ram_t       lookup_rd_data
);
   import msx_upload_pkg::*;

   logic              load;
   logic [RAM_AW-1:0] conf_size;
   logic              reader_busy;
   logic [7:0]        rd_data;
   logic              hdr_req;
   logic [DDR_AW-1:0] hdr_addr;
   logic              hdr_valid;
   logic              fill_req;
   logic [DDR_AW-1:0] fill_addr;
   logic              fill_valid;
   logic              fill_start;
   logic [RAM_AW-1:0] fill_base;
   logic [DDR_AW-1:0] fill_src;
   logic [RAM_AW-1:0] fill_bytes;
   fill_mode_t        fill_mode;
   logic              fill_busy;
   logic              fill_done;
   logic [DDR_AW-1:0] fill_next_src;
   logic              slot_wr_en;
   logic [5:0]        slot_wr_idx;
   block_t            slot_wr_data;
   logic [5:0]        slot_rd_a_idx;
   block_t            slot_rd_a_data;
   logic              lookup_wr_en;
   logic [3:0]        lookup_wr_idx;
   lookup_ram_t       lookup_wr_data;

   upload_trigger u_trigger (
      .clk, .rst_n, .ioctl_download, .ioctl_index, .ioctl_addr,
      .load, .conf_size
   );

   ddr_byte_reader u_reader (
      .clk, .rst_n, .hdr_req, .hdr_addr, .fill_req, .fill_addr, .ddr_dat_i, .ddr_ack,
      .busy(reader_busy), .rd_data, .hdr_valid, .fill_valid, .ddr_cyc, .ddr_stb, .ddr_adr
   );

   ram_filler u_filler (
      .clk, .rst_n, .fill_start, .fill_base, .fill_src, .fill_bytes, .fill_mode,
      .fill_valid, .rd_data, .reader_busy, .ram_ack,
      .busy(fill_busy), .fill_done, .fill_next_src, .fill_req, .fill_addr,
      .ram_cyc, .ram_stb, .ram_adr, .ram_dat_o
   );

   config_sequencer u_sequencer (
      .clk, .rst_n, .load, .conf_size, .hdr_valid, .rd_data, .reader_busy,
      .fill_busy, .fill_done, .fill_next_src, .slot_rd_a_data,
      .reset_rq, .hdr_req, .hdr_addr, .fill_start, .fill_base, .fill_src, .fill_bytes,
      .fill_mode, .slot_wr_en, .slot_wr_idx, .slot_wr_data, .slot_rd_a_idx,
      .lookup_wr_en, .lookup_wr_idx, .lookup_wr_data, .bios_config
   );

   entry_table #(.entry_t(block_t), .DEPTH(SLOT_ENTRIES)) u_slot_table (
      .clk, .rst_n, .wr_en(slot_wr_en), .wr_idx(slot_wr_idx), .wr_data(slot_wr_data),
      .rd_a_idx(slot_rd_a_idx), .rd_b_idx(slot_rd_idx),
      .rd_a_data(slot_rd_a_data), .rd_b_data(slot_rd_data)
   );

   entry_table #(.entry_t(lookup_ram_t), .DEPTH(LOOKUP_ENTRIES)) u_lookup_table (
      .clk, .rst_n, .wr_en(lookup_wr_en), .wr_idx(lookup_wr_idx), .wr_data(lookup_wr_data),
      .rd_a_idx(4'd0), .rd_b_idx(lookup_rd_idx),
      .rd_a_data(), .rd_b_data(lookup_rd_data)
   );

endmodule

// File: ram_filler.sv
`timescale 1ns/1ps

module ram_filler (
   input  logic                              clk,
   input  logic                              rst_n,
   input  logic                              fill_start,
   input  logic [msx_upload_pkg::RAM_AW-1:0] fill_base,
   input  logic [msx_upload_pkg::DDR_AW-1:0] fill_src,
   input  logic [msx_upload_pkg::RAM_AW-1:0] fill_bytes,
   input  msx_upload_pkg::fill_mode_t        fill_mode,
   input  logic                              fill_valid,
   input  logic [7:0]                        rd_data,
   input  logic                              reader_busy,
   input  logic                              ram_ack,
   output logic                              busy,
   output logic                              fill_done,
   output logic [msx_upload_pkg::DDR_AW-1:0] fill_next_src,
   output logic                              fill_req,
   output logic [msx_upload_pkg::DDR_AW-1:0] fill_addr,
   output logic                              ram_cyc,
   output logic                              ram_stb,
   output logic [msx_upload_pkg::RAM_AW-1:0] ram_adr,
   output logic [7:0]                        ram_dat_o
);
   import msx_upload_pkg::*;

   fill_mode_t        mode;
   logic [RAM_AW-1:0] wr_left;
   logic [RAM_AW-1:0] rd_left;
   logic [DDR_AW-1:0] src;
   logic              rd_pend;
   logic              buf_full;
   logic [7:0]        buf_data;
   logic              wr_go;

   // Next source byte may be fetched while the current write is in flight
   assign fill_req = busy & (mode == FILL_COPY) & (rd_left != '0)
                   & ~rd_pend & ~buf_full & ~reader_busy;
   assign wr_go    = busy & ~ram_cyc & (wr_left != '0)
                   & ((mode == FILL_CHECKER) | buf_full);

   assign fill_addr     = src;
   assign fill_next_src = src;
   assign ram_stb       = ram_cyc;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         busy      <= 1'b0;
         fill_done <= 1'b0;
         ram_cyc   <= 1'b0;
         rd_pend   <= 1'b0;
         buf_full  <= 1'b0;
         wr_left   <= '0;
         rd_left   <= '0;
         mode      <= FILL_COPY;
      end else begin
         fill_done <= 1'b0;
         if (fill_start) begin
            busy    <= 1'b1;
            mode    <= fill_mode;
            wr_left <= fill_bytes;
            rd_left <= (fill_mode == FILL_COPY) ? fill_bytes : '0;
         end
         if (fill_req) begin
            rd_pend <= 1'b1;
            rd_left <= rd_left - 1'b1;
         end
         if (fill_valid) begin
            rd_pend  <= 1'b0;
            buf_full <= 1'b1;
         end
         if (wr_go) begin
            ram_cyc  <= 1'b1;
            buf_full <= 1'b0;
         end
         if (ram_cyc && ram_ack) begin
            ram_cyc <= 1'b0;
            wr_left <= wr_left - 1'b1;
            if (wr_left == RAM_AW'(1)) begin        // Last byte acked
               busy      <= 1'b0;
               fill_done <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (fill_start) begin
         ram_adr <= fill_base;
         src     <= fill_src;
      end
      if (fill_req) src <= src + 1'b1;
      if (fill_valid) buf_data <= rd_data;
      if (wr_go) begin
         if (mode == FILL_COPY) ram_dat_o <= buf_data;
         else ram_dat_o <= (ram_adr[8] == ram_adr[1]) ? 8'hFF : 8'h00;   // RAM checker
      end
      if (ram_cyc && ram_ack) ram_adr <= ram_adr + 1'b1;
   end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator; the log decides pass or fail
rm -f build.log sim.log
verilator --binary --timing -Wno-fatal -f msx_upload.f --top-module tb_msx_upload \
   -o tb_msx_upload > build.log 2>&1 \
   && ./obj_dir/tb_msx_upload > sim.log 2>&1 \
   || echo "TEST FAILED" >> sim.log
cat sim.log
! grep -q "TEST FAILED" sim.log && grep -q "TEST OK" sim.log \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

// File: tb_msx_upload.sv
`timescale 1ns/1ps

module tb_msx_upload;
   import msx_upload_pkg::*;

   localparam int N_WORDS   = 82;
   localparam int HDR_BASE  = 6;                    // First header byte word
   localparam int BIOS_WORD = 70;
   localparam int PAIR_WORD = 71;                   // Slot check count, then pairs

   logic                clk = 1'b0;
   logic                rst_n;
   logic                ioctl_download;
   logic [15:0]         ioctl_index;
   logic [RAM_AW-1:0]   ioctl_addr;
   logic [7:0]          ddr_dat_i;
   logic                ddr_ack;
   logic                ram_ack;
   logic [5:0]          slot_rd_idx;
   logic [3:0]          lookup_rd_idx;
   logic                reset_rq;
   logic                ddr_cyc;
   logic                ddr_stb;
   logic [DDR_AW-1:0]   ddr_adr;
   logic                ram_cyc;
   logic                ram_stb;
   logic [RAM_AW-1:0]   ram_adr;
   logic [7:0]          ram_dat_o;
   bios_config_t        bios_config;
   block_t              slot_rd_data;
   lookup_ram_t         lookup_rd_data;

   logic [31:0] input_words [N_WORDS];
   logic [63:0] slot_expect [SLOT_ENTRIES];
   logic [63:0] lookup_expect [LOOKUP_ENTRIES];
   int          region_base [$];
   int          region_bytes [$];
   int          region_src [$];
   bit          region_checker [$];
   int          n_records;
   int          fill_total;
   int          watchdog_cycles = 0;

   msx_upload_top u_dut (
      .clk, .rst_n, .ioctl_download, .ioctl_index, .ioctl_addr, .ddr_dat_i, .ddr_ack,
      .ram_ack, .slot_rd_idx, .lookup_rd_idx, .reset_rq, .ddr_cyc, .ddr_stb, .ddr_adr,
      .ram_cyc, .ram_stb, .ram_adr, .ram_dat_o, .bios_config, .slot_rd_data, .lookup_rd_data
   );

   ddr_read_slave u_ddr (
      .clk, .rst_n, .cyc(ddr_cyc), .stb(ddr_stb), .adr(ddr_adr), .dat(ddr_dat_i), .ack(ddr_ack)
   );

   ram_write_slave u_ram (
      .clk, .rst_n, .cyc(ram_cyc), .stb(ram_stb), .adr(ram_adr), .dat(ram_dat_o), .ack(ram_ack)
   );

   always #5 clk = ~clk;

   task automatic check_value(input logic [63:0] got, input logic [63:0] expected,
                              input string what);
      if (got !== expected) begin
         $display("mismatch at %0t ns: %s read %0h, expected %0h", $time, what, got, expected);
         $display("TEST FAILED");
         $fatal(1, "stopped at first error");
      end
   endtask

   function automatic logic [7:0] hdr_byte(input int rec, input int idx);
      return input_words[HDR_BASE + rec * HDR_BYTES + idx][7:0];
   endfunction

   // Lookup entries and RAM regions follow the record order and the running RAM pointer
   task automatic predict_regions();
      int         ram_ptr;
      int         n_pages;
      logic [7:0] b3;
      logic [7:0] b5;
      logic [7:0] id;
      ram_ptr    = 0;
      fill_total = 0;
      for (int i = 0; i < LOOKUP_ENTRIES; i++) lookup_expect[i] = '0;
      for (int r = 0; r < n_records; r++) begin
         b3      = hdr_byte(r, 3);
         b5      = hdr_byte(r, 5);
         id      = hdr_byte(r, 4);
         n_pages = {b5[2:0], hdr_byte(r, 6)};
         if (b3[7:4] == 4'd5 && n_pages != 0 && id != 8'h00) begin
            lookup_expect[region_base.size()] =
               {20'd0, RAM_AW'(ram_ptr), 16'(n_pages), 1'(id != 8'h01)};
            region_base.push_back(ram_ptr);
            region_bytes.push_back(n_pages << PAGE_SHIFT);
            region_src.push_back(input_words[2 + r] + HDR_BYTES);
            region_checker.push_back(id == 8'h01);
            ram_ptr    += n_pages << PAGE_SHIFT;
            fill_total += n_pages << PAGE_SHIFT;
         end
      end
   endtask

   task automatic download(input logic [15:0] index, input logic [RAM_AW-1:0] size);
      @(posedge clk);
      ioctl_index    <= index;
      ioctl_addr     <= size;
      ioctl_download <= 1'b1;
      repeat (8) @(posedge clk);
      ioctl_download <= 1'b0;
   endtask

   task automatic read_slot(input int idx, output logic [63:0] value);
      @(posedge clk);
      slot_rd_idx <= 6'(idx);
      @(negedge clk);
      value = 64'(slot_rd_data);
   endtask

   task automatic read_lookup(input int idx, output logic [63:0] value);
      @(posedge clk);
      lookup_rd_idx <= 4'(idx);
      @(negedge clk);
      value = 64'(lookup_rd_data);
   endtask

   task automatic check_ram();
      logic [31:0] a;
      logic [31:0] s;
      logic [7:0]  exp_byte;
      for (int q = 0; q < region_base.size(); q++) begin
         for (int i = 0; i < region_bytes[q]; i++) begin
            a = region_base[q] + i;
            s = region_src[q] + i;
            if (region_checker[q]) exp_byte = (a[8] == a[1]) ? 8'hFF : 8'h00;
            else exp_byte = s[7:0] ^ 8'h5A;       // Source byte rule of the DDR model
            check_value(u_ram.wr_count[a[15:0]], 1, $sformatf("writes to RAM %0h", a));
            check_value(u_ram.mem[a[15:0]], exp_byte, $sformatf("RAM byte %0h", a));
         end
      end
      check_value(u_ram.total_writes, fill_total, "total RAM writes");
      check_value(u_ram.stray_writes, 0, "RAM writes out of range");
   endtask

   // The walk ends at the configuration size
   always @(negedge clk) begin
      if (rst_n && ddr_cyc) begin
         check_value(ddr_adr < DDR_AW'(input_words[0]), 1,
                     $sformatf("DDR read %0h inside the configuration", ddr_adr));
      end
   end

   initial begin
      logic [63:0] value;
      rst_n          = 1'b0;
      ioctl_download = 1'b0;
      ioctl_index    = '0;
      ioctl_addr     = '0;
      slot_rd_idx    = '0;
      lookup_rd_idx  = '0;
      void'($urandom(58));
      $readmemh("upload_input.txt", input_words);
      n_records = input_words[1];
      for (int r = 0; r < n_records; r++) begin
         for (int b = 0; b < HDR_BYTES; b++) begin
            u_ddr.hdr_mem[input_words[2 + r] + b] = hdr_byte(r, b);
         end
      end
      for (int i = 0; i < SLOT_ENTRIES; i++) begin
         slot_expect[i] = 64'({MAPPER_UNUSED, DEVICE_NONE, 4'd0, 2'd0, 1'b0});
      end
      for (int p = 0; p < input_words[PAIR_WORD]; p++) begin
         slot_expect[input_words[PAIR_WORD + 1 + 2 * p]] = 64'(input_words[PAIR_WORD + 2 + 2 * p]);
      end
      predict_regions();
      watchdog_cycles = 8 * fill_total + 200 * n_records + 1000;
      repeat (2) @(posedge clk);
      rst_n <= 1'b1;

      @(negedge clk);
      check_value(reset_rq, 0, "reset_rq after reset");
      check_value(ddr_cyc, 0, "ddr_cyc after reset");
      check_value(ram_cyc, 0, "ram_cyc after reset");
      for (int i = 0; i < SLOT_ENTRIES; i++) begin
         read_slot(i, value);
         check_value(value, 0, $sformatf("slot entry %0d after reset", i));
      end

      download(16'd2, RAM_AW'(input_words[0]));     // Not a configuration download
      repeat (6) begin
         @(negedge clk);
         check_value(reset_rq, 0, "reset_rq after a download with index 2");
      end
      download(16'd1, RAM_AW'(input_words[0]));
      repeat (3) @(negedge clk);
      check_value(reset_rq, 1, "reset_rq after the configuration download");
      while (reset_rq) @(negedge clk);

      check_value(64'(bios_config), 64'(input_words[BIOS_WORD][5:0]), "bios_config");
      for (int i = 0; i < SLOT_ENTRIES; i++) begin
         read_slot(i, value);
         check_value(value, slot_expect[i], $sformatf("slot entry %0d", i));
      end
      for (int i = 0; i < LOOKUP_ENTRIES; i++) begin
         read_lookup(i, value);
         check_value(value, lookup_expect[i], $sformatf("lookup entry %0d", i));
      end
      check_ram();
      check_value(ddr_cyc, 0, "ddr_cyc after the load");
      check_value(ram_cyc, 0, "ram_cyc after the load");
      $display("TEST OK");
      $finish;
   end

   initial begin
      wait (watchdog_cycles > 0);
      repeat (watchdog_cycles) @(posedge clk);
      $display("watchdog: load never finished");
      $display("TEST FAILED");
      $fatal(1, "timeout");
   end

endmodule

// File: tb_wb_mem_models.sv
`timescale 1ns/1ps

module ddr_read_slave (
   input  logic                              clk,
   input  logic                              rst_n,
   input  logic                              cyc,
   input  logic                              stb,
   input  logic [msx_upload_pkg::DDR_AW-1:0] adr,
   output logic [7:0]                        dat,
   output logic                              ack
);
   import msx_upload_pkg::*;

   logic [7:0]  hdr_mem [int];                     // Header bytes by DDR address
   logic        active;
   int unsigned wait_cnt;

   function automatic logic [7:0] byte_at(input logic [DDR_AW-1:0] a);
      if (hdr_mem.exists(int'(a))) return hdr_mem[int'(a)];
      return a[7:0] ^ 8'h5A;                        // Filler bytes
   endfunction

   initial begin
      ack = 1'b0;
      dat = 8'h00;
   end

   always @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ack      <= 1'b0;
         dat      <= 8'h00;
         active   <= 1'b0;
         wait_cnt <= 0;
      end else if (ack) begin
         ack    <= 1'b0;
         active <= 1'b0;
      end else if (cyc && stb) begin
         if (!active) begin
            active   <= 1'b1;
            wait_cnt <= $urandom % 4;              // 0 to 3 extra cycles
         end else if (wait_cnt == 0) begin
            ack <= 1'b1;
            dat <= byte_at(adr);
         end else begin
            wait_cnt <= wait_cnt - 1;
         end
      end
   end

endmodule

module ram_write_slave (
   input  logic                              clk,
   input  logic                              rst_n,
   input  logic                              cyc,
   input  logic                              stb,
   input  logic [msx_upload_pkg::RAM_AW-1:0] adr,
   input  logic [7:0]                        dat,
   output logic                              ack
);

   logic [7:0]  mem [65536];
   int unsigned wr_count [65536];
   int unsigned total_writes;
   int unsigned stray_writes;                       // Writes above the modeled range
   logic        active;
   int unsigned wait_cnt;

   initial begin
      ack          = 1'b0;
      total_writes = 0;
      stray_writes = 0;
      for (int i = 0; i < 65536; i++) begin
         mem[i]      = 8'h00;
         wr_count[i] = 0;
      end
   end

   always @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ack      <= 1'b0;
         active   <= 1'b0;
         wait_cnt <= 0;
      end else if (ack) begin
         ack    <= 1'b0;
         active <= 1'b0;
      end else if (cyc && stb) begin
         if (!active) begin
            active   <= 1'b1;
            wait_cnt <= $urandom % 4;
         end else if (wait_cnt == 0) begin
            ack          <= 1'b1;
            total_writes <= total_writes + 1;
            if (adr < 65536) begin
               mem[adr[15:0]]      <= dat;
               wr_count[adr[15:0]] <= wr_count[adr[15:0]] + 1;
            end else begin
               stray_writes <= stray_writes + 1;
            end
         end else begin
            wait_cnt <= wait_cnt - 1;
         end
      end
   end

endmodule

// File: upload_input.txt
// conf_size, record count, DDR address of each record; then 16 header bytes per record,
// bios_config, slot check count and (slot index, expected entry) pairs
00004240 00000004 00000000 00004010 00004020 00004230
4D 53 58 50 02 00 01 00 03 18 10 00 00 00 00 00
4D 53 58 54 01 00 02 01 01 3A 24 00 00 00 00 00
4D 53 58 60 00 00 00 00 00 00 00 00 00 00 00 00
4D 53 58 70 2B 00 00 00 00 00 00 00 00 00 00 00
2E
5
1 18000
2 18000
10 8088
11 808A
12 7F808C

// File: upload_trigger.sv
`timescale 1ns/1ps

module upload_trigger (
   input  logic                              clk,
   input  logic                              rst_n,
   input  logic                              ioctl_download,
   input  logic [15:0]                       ioctl_index,
   input  logic [msx_upload_pkg::RAM_AW-1:0] ioctl_addr,
   output logic                              load,
   output logic [msx_upload_pkg::RAM_AW-1:0] conf_size
);

   logic download_d;
   logic conf_end;

   assign conf_end = download_d & ~ioctl_download & (ioctl_index[5:0] == 6'd1);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         download_d <= 1'b0;
         load       <= 1'b0;
      end else begin
         download_d <= ioctl_download;
         load       <= conf_end;
      end
   end

   always_ff @(posedge clk) begin
      if (conf_end) conf_size <= ioctl_addr;      // Final ioctl address is the size
   end

endmodule
